// File: sources.f
+incdir+src
src/uart_pkg.sv
src/baud_divider.sv
src/bit_timer.sv
src/tx_shifter.sv
src/tx_fsm.sv
src/uart_tx_top.sv
sim/clk_gen.sv
sim/tb_uart_tx.sv

// File: Makefile
# Verilator build and run for the UART transmitter

VERILATOR ?= verilator
TOP       ?= tb_uart_tx
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= FAIL: see errors above

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard src/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# A crash without a report also counts as a failure
run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_uart_tx.sv
// UART transmitter testbench
`include "uart_defines.svh"

module tb_uart_tx;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned RAND_SEED  = 50952;
  localparam int unsigned NUM_RANDOM = 20;
  localparam int unsigned SETTLE     = 40;  // Divider result lands 34 cycles after a change

  // Baud port is 16 bits wide, so every rate stays below 65536
  localparam logic [15:0] FAST_BAUD = 16'd57_600;
  localparam logic [15:0] MID_BAUD  = 16'd38_400;
  localparam logic [15:0] SLOW_BAUD = 16'd19_200;
  localparam logic [15:0] LOW_BAUD  = 16'd100;  // Quotient wider than 16 bits

  localparam int unsigned P_FAST = `UART_CLK_FREQ / 32'(FAST_BAUD);
  localparam int unsigned P_MID  = `UART_CLK_FREQ / 32'(MID_BAUD);
  localparam int unsigned P_SLOW = `UART_CLK_FREQ / 32'(SLOW_BAUD);
  localparam int unsigned P_DEF  = 32'(`UART_DEFAULT_PERIOD);

  // All frames at their periods, the idle waits and a margin
  localparam int unsigned TIMEOUT_CYCLES =
    32'(`UART_FRAME_BITS) * ((NUM_RANDOM + 2) * P_FAST + 2 * P_MID + P_SLOW + 2 * P_DEF) +
    10 * P_FAST + 4000;

  logic                    sys_clk;
  logic                    rst_n;
  logic [15:0]             baud_val;
  logic [`UART_DATA_W-1:0] tx_data;
  logic                    tx_start;
  logic                    tx_out;
  logic                    tx_busy;
  logic                    tx_done;

  // Reference model
  logic                        exp_active;  // Frame on the line
  logic                        exp_done;    // Done pulse due this cycle
  logic [31:0]                 exp_cyc;     // Edges since the frame start
  logic [31:0]                 exp_period;
  logic [`UART_FRAME_BITS-1:0] exp_frame;
  logic [31:0]                 phase;
  logic [31:0]                 frame_len;
  logic [3:0]                  bit_idx;
  logic                        mid_bit;
  logic                        exp_bit;

  int          mismatches;
  int          other_errors;
  int unsigned cycle_count;

  clk_gen i_clk_gen (
    .sys_clk (sys_clk),
    .rst_n   (rst_n)
  );

  uart_tx_top i_uart_tx_top (
    .sys_clk  (sys_clk),
    .rst_n    (rst_n),
    .baud_val (baud_val),
    .tx_data  (tx_data),
    .tx_start (tx_start),
    .tx_out   (tx_out),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done)
  );

  // Cycles per bit for a requested rate, default when unusable
  function automatic logic [31:0] expected_period(input logic [15:0] baud);
    logic [31:0] quotient;
    if (baud == 16'd0) begin
      return 32'(`UART_DEFAULT_PERIOD);
    end
    quotient = `UART_CLK_FREQ / {16'd0, baud};
    if ((quotient == 32'd0) || (quotient >= (32'd1 << `UART_PERIOD_W))) begin
      return 32'(`UART_DEFAULT_PERIOD);
    end
    return quotient;
  endfunction

  assign frame_len = exp_period * 32'(`UART_FRAME_BITS);
  assign phase     = (exp_cyc - 32'd1) % exp_period;
  assign bit_idx   = 4'((exp_cyc - 32'd1) / exp_period);
  assign mid_bit   = exp_active && (phase == (exp_period >> 1));
  assign exp_bit   = exp_frame[bit_idx];

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_active <= 1'b0;
      exp_done   <= 1'b0;
      exp_cyc    <= '0;
      exp_period <= 32'(`UART_DEFAULT_PERIOD);
      exp_frame  <= '1;
    end else begin
      exp_done <= 1'b0;
      if (exp_active) begin
        exp_cyc <= exp_cyc + 32'd1;
        if (exp_cyc == frame_len) begin  // Last stop-bit cycle
          exp_active <= 1'b0;
          exp_done   <= 1'b1;
        end
      end
      if (tx_start && !exp_active) begin
        exp_active <= 1'b1;
        exp_cyc    <= 32'd1;
        exp_period <= expected_period(baud_val);  // Fixed for the whole frame
        exp_frame  <= {1'b1, tx_data, 1'b0};
      end
    end
  end

  task automatic report_mismatch(input string name, input logic expected, input logic actual);
    mismatches++;
    $display("Mismatch at %0d ns: %s expected %b actual %b", $time, name, expected, actual);
  endtask

  mid_bit_a : assert property (@(posedge sys_clk) disable iff (!rst_n)
    mid_bit |-> (tx_out == exp_bit))
    else report_mismatch("tx_out", $sampled(exp_bit), $sampled(tx_out));

  idle_line_a : assert property (@(posedge sys_clk) disable iff (!rst_n)
    !exp_active |-> tx_out)
    else report_mismatch("tx_out", 1'b1, $sampled(tx_out));

  busy_match_a : assert property (@(posedge sys_clk) disable iff (!rst_n)
    tx_busy == exp_active)
    else report_mismatch("tx_busy", $sampled(exp_active), $sampled(tx_busy));

  done_match_a : assert property (@(posedge sys_clk) disable iff (!rst_n)
    tx_done == exp_done)
    else report_mismatch("tx_done", $sampled(exp_done), $sampled(tx_done));

  // Line may only move on a bit boundary
  bit_edge_a : assert property (@(posedge sys_clk) disable iff (!rst_n)
    (exp_active && (tx_out != $past(tx_out))) |-> (phase == 32'd0))
    else begin
      other_errors++;
      $display("At %0d ns tx_out changed %0d cycles into a %0d-cycle bit",
               $time, $sampled(phase), $sampled(exp_period));
    end

  task automatic wait_cycles(input int unsigned n);
    repeat (n) @(posedge sys_clk);
  endtask

  task automatic set_baud(input logic [15:0] baud);
    @(posedge sys_clk);
    baud_val <= baud;
    wait_cycles(SETTLE);
  endtask

  task automatic start_frame(input logic [`UART_DATA_W-1:0] data);
    @(posedge sys_clk);
    tx_data  <= data;
    tx_start <= 1'b1;
    @(posedge sys_clk);
    tx_start <= 1'b0;
  endtask

  // Read between edges where the pulse is stable
  task automatic wait_for_done();
    do begin
      @(negedge sys_clk);
    end while (tx_done !== 1'b1);
  endtask

  task automatic send_byte(input logic [`UART_DATA_W-1:0] data);
    start_frame(data);
    wait_for_done();
  endtask

  task automatic close_run();
    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    if ((mismatches + other_errors) != 0) begin
      $display("FAIL: see errors above");
    end else begin
      $display("PASS: all tests");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    baud_val <= FAST_BAUD;
    tx_data  <= '0;
    tx_start <= 1'b0;
    @(posedge rst_n);
    wait_cycles(SETTLE);  // First division after reset

    repeat (NUM_RANDOM) begin
      send_byte(8'($urandom));
    end

    // New rate, then a rate change in the middle of a frame
    set_baud(MID_BAUD);
    send_byte(8'($urandom));
    start_frame(8'hA5);
    wait_cycles(4 * P_MID + 7);
    @(posedge sys_clk);
    baud_val <= SLOW_BAUD;
    wait_for_done();
    wait_cycles(SETTLE);
    send_byte(8'h3C);

    // Unusable quotients
    set_baud(16'd0);
    send_byte(8'($urandom));
    set_baud(FAST_BAUD);  // Short period first so the fallback shows
    set_baud(LOW_BAUD);
    send_byte(8'($urandom));

    // Second strobe lands while the first frame is on the line
    set_baud(FAST_BAUD);
    start_frame(8'h96);
    wait_cycles(3 * P_FAST + 5);
    start_frame(8'h69);
    wait_for_done();
    wait_cycles(2 * P_FAST);
    close_run();
  end

  always @(posedge sys_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      other_errors++;
      $display("Timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
      close_run();
    end
  end

endmodule

// File: sim/clk_gen.sv
// Testbench clock and reset
module clk_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 16
) (
  output logic sys_clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    sys_clk = 1'b0;
    forever #(PERIOD_NS / 2) sys_clk = ~sys_clk;
  end

  // Release between edges so no flop sees it at a clock edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge sys_clk);
    @(negedge sys_clk);
    rst_n = 1'b1;
  end

endmodule

// File: src/uart_tx_top.sv
// UART transmitter top level
`include "uart_defines.svh"

module uart_tx_top (
  input  logic                    sys_clk,
  input  logic                    rst_n,
  input  logic [15:0]             baud_val,  // Requested baud rate
  input  logic [`UART_DATA_W-1:0] tx_data,
  input  logic                    tx_start,
  output logic                    tx_out,
  output logic                    tx_busy,
  output logic                    tx_done
);

  uart_pkg::period_upd_t period_upd;
  uart_pkg::timer_ctl_t  timer_ctl;
  uart_pkg::shift_ctl_t  shift_ctl;
  logic                  tick;

  baud_divider i_baud_divider (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .baud_val   (baud_val),
    .period_upd (period_upd)
  );

  bit_timer i_bit_timer (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .timer_ctl (timer_ctl),
    .tick      (tick)
  );

  tx_shifter i_tx_shifter (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .shift_ctl (shift_ctl),
    .tx_out    (tx_out)
  );

  tx_fsm i_tx_fsm (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .tx_start   (tx_start),
    .tx_data    (tx_data),
    .period_upd (period_upd),
    .tick       (tick),
    .timer_ctl  (timer_ctl),
    .shift_ctl  (shift_ctl),
    .tx_busy    (tx_busy),
    .tx_done    (tx_done)
  );

endmodule

// File: src/tx_fsm.sv
// Transmit control FSM
`include "uart_defines.svh"

module tx_fsm (
  input  logic                    sys_clk,
  input  logic                    rst_n,
  input  logic                    tx_start,
  input  logic [`UART_DATA_W-1:0] tx_data,
  input  uart_pkg::period_upd_t   period_upd,
  input  logic                    tick,
  output uart_pkg::timer_ctl_t    timer_ctl,
  output uart_pkg::shift_ctl_t    shift_ctl,
  output logic                    tx_busy,
  output logic                    tx_done
);

  typedef enum logic {
    IDLE,
    SEND
  } state_t;

  localparam int CNT_W = $clog2(`UART_FRAME_BITS);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`UART_FRAME_BITS - 1);

  state_t                    state;
  logic [CNT_W-1:0]          bit_cnt;       // Bit now on the line
  logic [`UART_PERIOD_W-1:0] period_next;   // Latest divider result
  logic [`UART_PERIOD_W-1:0] period_frame;  // Held for the whole frame
  logic                      frame_go;
  logic                      last_tick;

  assign frame_go  = (state == IDLE) && tx_start;
  assign last_tick = (state == SEND) && tick && (bit_cnt == LAST_BIT);
  assign tx_busy   = (state == SEND);

  // Timer control
  assign timer_ctl.restart = frame_go;
  assign timer_ctl.run     = (state == SEND);
  assign timer_ctl.period  = (state == IDLE) ? period_next : period_frame;

  // Shifter control
  assign shift_ctl.load  = frame_go;
  assign shift_ctl.shift = (state == SEND) && tick && !last_tick;
  assign shift_ctl.data  = tx_data;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= IDLE;
      bit_cnt     <= '0;
      tx_done     <= 1'b0;
      period_next <= `UART_DEFAULT_PERIOD;
    end else begin
      tx_done <= 1'b0;
      if (period_upd.valid) begin
        period_next <= period_upd.period;  // Used from the next frame
      end
      case (state)
        IDLE: begin
          if (tx_start) begin
            state   <= SEND;
            bit_cnt <= '0;
          end
        end
        SEND: begin
          if (last_tick) begin
            state   <= IDLE;
            tx_done <= 1'b1;
          end else if (tick) begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (frame_go) begin
      period_frame <= period_next;
    end
  end

  // Done follows the last busy cycle
  done_after_busy_a : assert property (@(posedge sys_clk) disable iff (!rst_n)
    tx_done |-> ($past(tx_busy) && !tx_busy));

endmodule

// File: src/tx_shifter.sv
// Serial frame shifter
`include "uart_defines.svh"

module tx_shifter (
  input  logic                 sys_clk,
  input  logic                 rst_n,
  input  uart_pkg::shift_ctl_t shift_ctl,
  output logic                 tx_out
);

  localparam int FRAME_W = `UART_FRAME_BITS;

  // Bit 0 is the one on the line
  logic [FRAME_W-1:0] frame;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      frame <= '1;  // Line idles high
    end else if (shift_ctl.load) begin
      frame <= {1'b1, shift_ctl.data, 1'b0};  // Stop, data, start
    end else if (shift_ctl.shift) begin
      // Ones fill from the top so the line ends high
      frame <= {1'b1, frame[FRAME_W-1:1]};
    end
  end

  assign tx_out = frame[0];

  // FSM never asks for both in one cycle
  load_shift_excl_a : assert property (@(posedge sys_clk) disable iff (!rst_n)
    !(shift_ctl.load && shift_ctl.shift));

endmodule

// File: src/bit_timer.sv
// Bit period timer
`include "uart_defines.svh"

module bit_timer (
  input  logic                 sys_clk,
  input  logic                 rst_n,
  input  uart_pkg::timer_ctl_t timer_ctl,
  output logic                 tick
);

  logic [`UART_PERIOD_W-1:0] count;   // Cycles left in this bit
  logic [`UART_PERIOD_W-1:0] reload;

  assign reload = timer_ctl.period - 1'b1;

  // Last cycle of the bit
  assign tick = timer_ctl.run && (count == '0);

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (timer_ctl.restart) begin
      count <= reload;
    end else if (timer_ctl.run) begin
      if (tick) begin
        count <= reload;  // Next bit starts without a gap
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  // Running count stays inside the bit period
  count_in_bit_a : assert property (@(posedge sys_clk) disable iff (!rst_n)
    timer_ctl.run |-> (count < timer_ctl.period));

endmodule

// File: src/baud_divider.sv
// Baud rate to bit period divider
`include "uart_defines.svh"

module baud_divider (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  input  logic [15:0]           baud_val,
  output uart_pkg::period_upd_t period_upd
);

  localparam int BAUD_W = 16;
  localparam int DVD_W  = 32;
  localparam int CNT_W  = $clog2(DVD_W + 1);
  localparam logic [DVD_W-1:0] CLK_FREQ = `UART_CLK_FREQ;

  logic [BAUD_W-1:0] baud_prev;
  logic              init_pend;  // Forces one division out of reset
  logic              div_start;
  logic              div_busy;
  logic              div_fin;
  logic [CNT_W-1:0]  div_cnt;    // Iterations left
  logic [DVD_W-1:0]  dvd_sh;
  logic [DVD_W-1:0]  quo;
  logic [BAUD_W-1:0] rem;
  logic [BAUD_W-1:0] dvsr;
  logic [BAUD_W:0]   rem_sh;
  logic [BAUD_W:0]   rem_sub;
  logic              quo_bad;

  // A new request also cancels a division in flight
  assign div_start = init_pend || (baud_val != baud_prev);

  // Trial subtraction for one quotient bit
  assign rem_sh  = {rem, dvd_sh[DVD_W-1]};
  assign rem_sub = rem_sh - {1'b0, dvsr};

  // Zero divisor, zero quotient or too long for a period
  assign quo_bad = (dvsr == '0) || (quo == '0) ||
                   (quo[DVD_W-1:`UART_PERIOD_W] != '0);

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      baud_prev <= '0;
      init_pend <= 1'b1;
      div_busy  <= 1'b0;
      div_fin   <= 1'b0;
      div_cnt   <= '0;
    end else begin
      init_pend <= 1'b0;
      baud_prev <= baud_val;
      div_fin   <= 1'b0;
      if (div_start) begin
        div_busy <= 1'b1;
        div_cnt  <= CNT_W'(DVD_W);
      end else if (div_busy) begin
        div_cnt <= div_cnt - 1'b1;
        if (div_cnt == CNT_W'(1)) begin  // Last quotient bit this cycle
          div_busy <= 1'b0;
          div_fin  <= 1'b1;
        end
      end
    end
  end

  // Restoring division datapath
  always_ff @(posedge sys_clk) begin
    if (div_start) begin
      dvd_sh <= CLK_FREQ;
      dvsr   <= baud_val;
      rem    <= '0;
      quo    <= '0;
    end else if (div_busy) begin
      dvd_sh <= {dvd_sh[DVD_W-2:0], 1'b0};
      if (!rem_sub[BAUD_W]) begin
        rem <= rem_sub[BAUD_W-1:0];
        quo <= {quo[DVD_W-2:0], 1'b1};
      end else begin
        rem <= rem_sh[BAUD_W-1:0];      // Restore
        quo <= {quo[DVD_W-2:0], 1'b0};
      end
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      period_upd.valid  <= 1'b0;
      period_upd.period <= `UART_DEFAULT_PERIOD;
    end else begin
      period_upd.valid <= div_fin;
      if (div_fin) begin
        period_upd.period <= quo_bad ? `UART_DEFAULT_PERIOD : quo[`UART_PERIOD_W-1:0];
      end
    end
  end

  // The FSM must never see a zero bit period
  period_nonzero_a : assert property (@(posedge sys_clk) disable iff (!rst_n)
    period_upd.valid |-> (period_upd.period != '0));

endmodule

// File: src/uart_pkg.sv
// UART transmitter shared types
`include "uart_defines.svh"

package uart_pkg;

  // New bit period from the divider
  typedef struct packed {
    logic                      valid;   // One-cycle strobe
    logic [`UART_PERIOD_W-1:0] period;  // Cycles per bit
  } period_upd_t;

  // Frame register control from the FSM
  typedef struct packed {
    logic                    load;   // Capture a fresh frame
    logic                    shift;  // Move one bit toward the line
    logic [`UART_DATA_W-1:0] data;   // Byte for the load
  } shift_ctl_t;

  // Bit timer control from the FSM
  typedef struct packed {
    logic                      restart;  // Reload from period
    logic                      run;      // Count enable
    logic [`UART_PERIOD_W-1:0] period;   // Cycles per bit
  } timer_ctl_t;

endpackage

// File: src/uart_defines.svh
// UART transmitter build constants
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// System clock in Hz, used as the divider dividend
`define UART_CLK_FREQ 32'd10_000_000

// Bit period after reset and on a bad quotient
// 1042 cycles is roughly 9600 baud at 10 MHz
`define UART_DEFAULT_PERIOD 16'd1042

// Width of a bit period in clock cycles
`define UART_PERIOD_W 16

// Payload byte width
`define UART_DATA_W 8

// Start bit, eight data bits, stop bit
`define UART_FRAME_BITS 10

`endif
